/* exec_data_pkg.sv */
package exec_data_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Integer register width of the core.
    parameter int xlen = 32;

    // Shift amounts use the low bits of operand 2.
    parameter int shamt_w = 5;

    // Register, pc and immediate values.
    typedef logic [xlen-1:0] uint_x;

    // Shift amount.
    typedef logic [shamt_w-1:0] shamt_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // All zero data word.
    parameter uint_x data_zero = '0;

    // Unknown word, driven by a disabled datapath block.
    parameter uint_x data_x = 'x;

    // Jalr target mask, clears bit 0.
    parameter uint_x jalr_mask = ~uint_x'(1);

endpackage

/* exec_ctrl_pkg.sv */
package exec_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute control encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        alu_add      = 4'd0,
        alu_sub      = 4'd1,
        alu_and      = 4'd2,
        alu_or       = 4'd3,
        alu_xor      = 4'd4,
        alu_sll      = 4'd5,
        alu_srl      = 4'd6,
        alu_sra      = 4'd7,
        alu_slt      = 4'd8,
        alu_jalr     = 4'd9,
        alu_copy1    = 4'd10,
        alu_czero_eq = 4'd11,
        alu_czero_ne = 4'd12
    } alu_sel_t;

    // Branch condition, none means never taken.
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_beq  = 3'd1,
        br_bne  = 3'd2,
        br_blt  = 3'd3,
        br_bge  = 3'd4
    } br_sel_t;

    // Applies to slt, blt and bge.
    typedef enum logic {
        op_signed   = 1'b0,
        op_unsigned = 1'b1
    } sign_sel_t;

    typedef enum logic {
        op1_rs1 = 1'b0,
        op1_pc  = 1'b1
    } op1_src_t;

    typedef enum logic {
        op2_rs2 = 1'b0,
        op2_imm = 1'b1
    } op2_src_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        hs_idle = 2'd0,
        hs_busy = 2'd1,
        hs_done = 2'd2
    } hs_state_t;

endpackage

/* alu.sv */
`timescale 1ns/1ns

module alu #(
    parameter bit enable_alu    = 1'b0,
    parameter bit enable_branch = 1'b0
) (
    input  exec_ctrl_pkg::alu_sel_t  alu_op,
    input  exec_ctrl_pkg::br_sel_t   br_op,
    input  exec_ctrl_pkg::sign_sel_t sign_sel,
    input  exec_data_pkg::uint_x     op1,
    input  exec_data_pkg::uint_x     op2,
    output exec_data_pkg::uint_x     alu_out,
    output logic                     branch_take
);

    exec_data_pkg::shamt_t shamt;
    exec_data_pkg::uint_x  sum;
    exec_data_pkg::uint_x  alu_res;
    logic                  less;
    logic                  equal;
    logic                  br_res;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared terms
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign shamt = op2[exec_data_pkg::shamt_w-1:0];
    assign sum   = op1 + op2;
    assign equal = (op1 == op2);

    // One comparator serves slt, blt and bge.
    assign less = (sign_sel == exec_ctrl_pkg::op_signed) ?
                  ($signed(op1) < $signed(op2)) :
                  (op1 < op2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (alu_op)
            exec_ctrl_pkg::alu_add:   alu_res = sum;
            exec_ctrl_pkg::alu_sub:   alu_res = op1 - op2;
            exec_ctrl_pkg::alu_and:   alu_res = op1 & op2;
            exec_ctrl_pkg::alu_or:    alu_res = op1 | op2;
            exec_ctrl_pkg::alu_xor:   alu_res = op1 ^ op2;
            exec_ctrl_pkg::alu_sll:   alu_res = op1 << shamt;
            exec_ctrl_pkg::alu_srl:   alu_res = op1 >> shamt;
            exec_ctrl_pkg::alu_sra:   alu_res = $signed(op1) >>> shamt;
            exec_ctrl_pkg::alu_slt:   alu_res = {{(exec_data_pkg::xlen-1){1'b0}}, less};
            exec_ctrl_pkg::alu_jalr:  alu_res = sum & exec_data_pkg::jalr_mask;
            exec_ctrl_pkg::alu_copy1: alu_res = op1;
            exec_ctrl_pkg::alu_czero_eq: begin
                alu_res = (op2 == exec_data_pkg::data_zero) ? op1 : exec_data_pkg::data_zero;
            end
            exec_ctrl_pkg::alu_czero_ne: begin
                alu_res = (op2 != exec_data_pkg::data_zero) ? op1 : exec_data_pkg::data_zero;
            end
            // Unused codes.
            default:                  alu_res = exec_data_pkg::data_x;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch condition
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (br_op)
            exec_ctrl_pkg::br_beq: br_res = equal;
            exec_ctrl_pkg::br_bne: br_res = !equal;
            exec_ctrl_pkg::br_blt: br_res = less;
            exec_ctrl_pkg::br_bge: br_res = !less;
            default:               br_res = 1'b0;
        endcase
    end

    assign alu_out     = enable_alu    ? alu_res : exec_data_pkg::data_x;
    assign branch_take = enable_branch ? br_res  : 1'bx;

endmodule

/* operand_select.sv */
`timescale 1ns/1ns

module operand_select (
    input  exec_ctrl_pkg::op1_src_t op1_src,
    input  exec_ctrl_pkg::op2_src_t op2_src,
    input  exec_data_pkg::uint_x    rs1_data,
    input  exec_data_pkg::uint_x    rs2_data,
    input  exec_data_pkg::uint_x    pc,
    input  exec_data_pkg::uint_x    imm,
    output exec_data_pkg::uint_x    op1,
    output exec_data_pkg::uint_x    op2,
    output exec_data_pkg::uint_x    branch_target
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand muxes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Pc as operand 1 gives auipc and jal.
    assign op1 = (op1_src == exec_ctrl_pkg::op1_pc) ? pc : rs1_data;

    // Immediate forms for alu ops, loads and jalr.
    assign op2 = (op2_src == exec_ctrl_pkg::op2_imm) ? imm : rs2_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch target
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Separate adder so the ALU stays free for the compare.
    assign branch_target = pc + imm;

endmodule

/* exec_handshake.sv */
`timescale 1ns/1ns

module exec_handshake (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  exec_data_pkg::uint_x alu_out,
    input  logic                 branch_take_in,
    input  exec_data_pkg::uint_x branch_target_in,
    output logic                 ack,
    output exec_data_pkg::uint_x result,
    output logic                 branch_take,
    output exec_data_pkg::uint_x branch_target
);

    exec_ctrl_pkg::hs_state_t state;
    exec_ctrl_pkg::hs_state_t state_next;
    logic                     capture;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Four-phase FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign capture = (state == exec_ctrl_pkg::hs_idle) && req;

    always_comb begin
        state_next = state;
        case (state)
            exec_ctrl_pkg::hs_idle: begin
                if (req) begin
                    state_next = exec_ctrl_pkg::hs_done;
                end
            end
            exec_ctrl_pkg::hs_done: begin
                // Release once the requester lets go.
                if (!req) begin
                    state_next = exec_ctrl_pkg::hs_idle;
                end
            end
            exec_ctrl_pkg::hs_busy: begin
                // No capture here, wait out the stale req.
                if (!req) begin
                    state_next = exec_ctrl_pkg::hs_idle;
                end
            end
            default: state_next = exec_ctrl_pkg::hs_busy;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= exec_ctrl_pkg::hs_idle;
        end else begin
            state <= state_next;
        end
    end

    assign ack = (state == exec_ctrl_pkg::hs_done);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            result        <= exec_data_pkg::data_zero;
            branch_take   <= 1'b0;
            branch_target <= exec_data_pkg::data_zero;
        end else if (capture) begin
            result        <= alu_out;
            branch_take   <= branch_take_in;
            branch_target <= branch_target_in;
        end
    end

endmodule

/* exec_unit.sv */
`timescale 1ns/1ns

module exec_unit #(
    parameter bit enable_alu    = 1'b1,
    parameter bit enable_branch = 1'b1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  exec_data_pkg::uint_x     rs1_data,
    input  exec_data_pkg::uint_x     rs2_data,
    input  exec_data_pkg::uint_x     pc,
    input  exec_data_pkg::uint_x     imm,
    input  exec_ctrl_pkg::op1_src_t  op1_src,
    input  exec_ctrl_pkg::op2_src_t  op2_src,
    input  exec_ctrl_pkg::alu_sel_t  alu_op,
    input  exec_ctrl_pkg::br_sel_t   br_op,
    input  exec_ctrl_pkg::sign_sel_t sign_sel,
    output logic                     ack,
    output exec_data_pkg::uint_x     result,
    output logic                     branch_take,
    output exec_data_pkg::uint_x     branch_target
);

    exec_data_pkg::uint_x op1;
    exec_data_pkg::uint_x op2;
    exec_data_pkg::uint_x target_comb;
    exec_data_pkg::uint_x alu_out;
    logic                 take_comb;

    operand_select operand_select_i (
        .op1_src       (op1_src),
        .op2_src       (op2_src),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .pc            (pc),
        .imm           (imm),
        .op1           (op1),
        .op2           (op2),
        .branch_target (target_comb)
    );

    alu #(
        .enable_alu    (enable_alu),
        .enable_branch (enable_branch)
    ) alu_i (
        .alu_op      (alu_op),
        .br_op       (br_op),
        .sign_sel    (sign_sel),
        .op1         (op1),
        .op2         (op2),
        .alu_out     (alu_out),
        .branch_take (take_comb)
    );

    // Registers the combinational results and answers req.
    exec_handshake exec_handshake_i (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .alu_out          (alu_out),
        .branch_take_in   (take_comb),
        .branch_target_in (target_comb),
        .ack              (ack),
        .result           (result),
        .branch_take      (branch_take),
        .branch_target    (branch_target)
    );

endmodule

/* exec_unit_sva.sv */
`timescale 1ns/1ns

module exec_unit_sva (
    input logic                 clk,
    input logic                 reset,
    input logic                 req,
    input logic                 ack,
    input exec_data_pkg::uint_x result
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Four-phase handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ack_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else $error("ack high in the cycle after reset");

    ack_rise: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
        else $error("ack rose without req in the previous cycle");

    ack_fall: assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // Outputs frozen for the whole ack phase.
    result_hold: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(result))
        else $error("result changed while ack was high");

endmodule

bind exec_unit exec_unit_sva exec_unit_sva_i (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ack    (ack),
    .result (result)
);

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic reset
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Two cycles of reset, released just after an edge.
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* exec_unit_tb.sv */
`timescale 1ns/1ns

module exec_unit_tb;

    typedef struct packed {
        exec_ctrl_pkg::alu_sel_t  op;
        exec_ctrl_pkg::br_sel_t   br;
        exec_ctrl_pkg::sign_sel_t sg;
        logic [1:0]               src;
        exec_data_pkg::uint_x     rs1;
        exec_data_pkg::uint_x     rs2;
        exec_data_pkg::uint_x     pc;
        exec_data_pkg::uint_x     imm;
        exec_data_pkg::uint_x     res;
        logic                     take;
    } row_t;

    localparam int timeout_cycles = 16;
    localparam int random_rows    = 32;

    logic                     clk;
    logic                     reset;
    logic                     req;
    exec_data_pkg::uint_x     rs1_data;
    exec_data_pkg::uint_x     rs2_data;
    exec_data_pkg::uint_x     pc;
    exec_data_pkg::uint_x     imm;
    exec_ctrl_pkg::op1_src_t  op1_src;
    exec_ctrl_pkg::op2_src_t  op2_src;
    exec_ctrl_pkg::alu_sel_t  alu_op;
    exec_ctrl_pkg::br_sel_t   br_op;
    exec_ctrl_pkg::sign_sel_t sign_sel;
    logic                     ack;
    exec_data_pkg::uint_x     result;
    logic                     branch_take;
    exec_data_pkg::uint_x     branch_target;
    row_t                     rows[$];
    logic [31:0]              lfsr_state;
    int                       checks;
    int                       mismatches;
    int                       timeouts;

    tb_clock tb_clock_i (.clk(clk), .reset(reset));

    exec_unit #(.enable_alu(1'b1), .enable_branch(1'b1)) dut_i (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic row_t expected_row(input row_t r);
        row_t                 e;
        exec_data_pkg::uint_x a;
        exec_data_pkg::uint_x b;
        logic                 lt;
        e = r;
        a = r.src[1] ? r.pc : r.rs1;
        b = r.src[0] ? r.imm : r.rs2;
        lt = (r.sg == exec_ctrl_pkg::op_unsigned) ? (a < b) : ($signed(a) < $signed(b));
        case (r.op)
            exec_ctrl_pkg::alu_add:      e.res = a + b;
            exec_ctrl_pkg::alu_sub:      e.res = a - b;
            exec_ctrl_pkg::alu_and:      e.res = a & b;
            exec_ctrl_pkg::alu_or:       e.res = a | b;
            exec_ctrl_pkg::alu_xor:      e.res = a ^ b;
            exec_ctrl_pkg::alu_sll:      e.res = a << b[4:0];
            exec_ctrl_pkg::alu_srl:      e.res = a >> b[4:0];
            exec_ctrl_pkg::alu_sra:      e.res = $signed(a) >>> b[4:0];
            exec_ctrl_pkg::alu_slt:      e.res = {31'd0, lt};
            exec_ctrl_pkg::alu_jalr:     e.res = (a + b) & 32'hffff_fffe;
            exec_ctrl_pkg::alu_copy1:    e.res = a;
            exec_ctrl_pkg::alu_czero_eq: e.res = (b == 32'd0) ? a : 32'd0;
            exec_ctrl_pkg::alu_czero_ne: e.res = (b != 32'd0) ? a : 32'd0;
            default:                     e.res = 'x;
        endcase
        case (r.br)
            exec_ctrl_pkg::br_beq: e.take = (a == b);
            exec_ctrl_pkg::br_bne: e.take = (a != b);
            exec_ctrl_pkg::br_blt: e.take = lt;
            exec_ctrl_pkg::br_bge: e.take = !lt;
            default:               e.take = 1'b0;
        endcase
        return e;
    endfunction

    // src is {op1 from pc, op2 from imm}.
    task automatic add_row(input exec_ctrl_pkg::alu_sel_t op, input exec_ctrl_pkg::br_sel_t br,
                           input exec_ctrl_pkg::sign_sel_t sg, input logic [1:0] src,
                           input exec_data_pkg::uint_x rs1, input exec_data_pkg::uint_x rs2,
                           input exec_data_pkg::uint_x pc_v, input exec_data_pkg::uint_x imm_v,
                           input exec_data_pkg::uint_x res, input logic take);
        rows.push_back('{op, br, sg, src, rs1, rs2, pc_v, imm_v, res, take});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input exec_data_pkg::uint_x exp,
                               input exec_data_pkg::uint_x act);
        checks++;
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (ack !== level && cycles < timeout_cycles);
        if (ack !== level) begin
            timeouts++;
            $display("Timeout at %0t: ack did not go to %b within %0d cycles",
                     $time, level, timeout_cycles);
        end
    endtask

    // One four-phase transaction with req held for hold extra cycles.
    task automatic run_row(input row_t r, input int hold);
        int cycles;
        @(posedge clk);
        #1;
        rs1_data = r.rs1;
        rs2_data = r.rs2;
        pc = r.pc;
        imm = r.imm;
        op1_src = exec_ctrl_pkg::op1_src_t'(r.src[1]);
        op2_src = exec_ctrl_pkg::op2_src_t'(r.src[0]);
        alu_op = r.op;
        br_op = r.br;
        sign_sel = r.sg;
        req = 1'b1;
        wait_ack(1'b1, cycles);
        if (timeouts != 0) return;
        check_value("ack rise cycles", 32'd1, cycles);
        check_value("result", r.res, result);
        check_value("branch_take", {31'd0, r.take}, {31'd0, branch_take});
        check_value("branch_target", r.pc + r.imm, branch_target);
        // New operands must not leak into the held outputs.
        rs1_data = ~r.rs1;
        imm = r.imm + 32'd4;
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_value("result", r.res, result);
            check_value("branch_take", {31'd0, r.take}, {31'd0, branch_take});
            check_value("branch_target", r.pc + r.imm, branch_target);
        end
        req = 1'b0;
        wait_ack(1'b0, cycles);
        if (timeouts == 0) check_value("ack fall cycles", 32'd1, cycles);
    endtask

    initial begin
        row_t r;
        int   n;
        req = 1'b0;
        rs1_data = '0;
        rs2_data = '0;
        pc = '0;
        imm = '0;
        op1_src = exec_ctrl_pkg::op1_rs1;
        op2_src = exec_ctrl_pkg::op2_rs2;
        alu_op = exec_ctrl_pkg::alu_add;
        br_op = exec_ctrl_pkg::br_none;
        sign_sel = exec_ctrl_pkg::op_signed;
        lfsr_state = 32'd30;
        checks = 0;
        mismatches = 0;
        timeouts = 0;

        // Corner rows.
        add_row(exec_ctrl_pkg::alu_add, exec_ctrl_pkg::br_blt, exec_ctrl_pkg::op_unsigned,
                2'b00, 32'h7fffffff, 32'h1, 32'h100, 32'h8, 32'h80000000, 1'b0);
        add_row(exec_ctrl_pkg::alu_sub, exec_ctrl_pkg::br_bge, exec_ctrl_pkg::op_signed,
                2'b00, 32'h0, 32'h1, 32'h100, 32'hfffffffc, 32'hffffffff, 1'b0);
        add_row(exec_ctrl_pkg::alu_sll, exec_ctrl_pkg::br_bne, exec_ctrl_pkg::op_signed,
                2'b00, 32'h1, 32'h23, 32'h0, 32'h0, 32'h8, 1'b1);
        add_row(exec_ctrl_pkg::alu_sra, exec_ctrl_pkg::br_bge, exec_ctrl_pkg::op_unsigned,
                2'b00, 32'h80000000, 32'h4, 32'h0, 32'h0, 32'hf8000000, 1'b1);
        add_row(exec_ctrl_pkg::alu_slt, exec_ctrl_pkg::br_blt, exec_ctrl_pkg::op_signed,
                2'b00, 32'hffffffff, 32'h1, 32'h0, 32'h0, 32'h1, 1'b1);
        add_row(exec_ctrl_pkg::alu_slt, exec_ctrl_pkg::br_bge, exec_ctrl_pkg::op_unsigned,
                2'b00, 32'hffffffff, 32'h1, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(exec_ctrl_pkg::alu_czero_eq, exec_ctrl_pkg::br_bne, exec_ctrl_pkg::op_signed,
                2'b00, 32'h12345678, 32'h0, 32'h0, 32'h0, 32'h12345678, 1'b1);
        add_row(exec_ctrl_pkg::alu_czero_ne, exec_ctrl_pkg::br_bge, exec_ctrl_pkg::op_signed,
                2'b00, 32'h12345678, 32'h0, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(exec_ctrl_pkg::alu_copy1, exec_ctrl_pkg::br_none, exec_ctrl_pkg::op_signed,
                2'b00, 32'hdeadbeef, 32'hdeadbeef, 32'h0, 32'h0, 32'hdeadbeef, 1'b0);
        add_row(exec_ctrl_pkg::alu_jalr, exec_ctrl_pkg::br_none, exec_ctrl_pkg::op_signed,
                2'b01, 32'h1000, 32'hffffffff, 32'h200, 32'h7, 32'h1006, 1'b0);
        add_row(exec_ctrl_pkg::alu_add, exec_ctrl_pkg::br_beq, exec_ctrl_pkg::op_signed,
                2'b11, 32'h0, 32'h0, 32'h1000, 32'h800, 32'h1800, 1'b0);

        for (int i = 0; i < random_rows; i++) begin
            r.op = exec_ctrl_pkg::alu_sel_t'(4'(lfsr_bits(4)) % 4'd13);
            r.br = exec_ctrl_pkg::br_sel_t'(3'(lfsr_bits(3)) % 3'd5);
            r.sg = exec_ctrl_pkg::sign_sel_t'(1'(lfsr_bits(1)));
            r.src = 2'(lfsr_bits(2));
            r.rs1 = lfsr_bits(32);
            r.rs2 = lfsr_bits(32);
            r.pc = lfsr_bits(32);
            r.imm = lfsr_bits(32);
            // Some equal operands so beq and bge see ties.
            if (lfsr_bits(2) == 32'd0) begin
                r.rs2 = r.rs1;
            end
            rows.push_back(expected_row(r));
        end

        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset !== 1'b0 && n < timeout_cycles);
        if (reset !== 1'b0) begin
            timeouts++;
            $display("Timeout at %0t: reset never released", $time);
        end else begin
            check_value("ack", 32'd0, {31'd0, ack});
            check_value("result", 32'd0, result);
            check_value("branch_take", 32'd0, {31'd0, branch_take});
            check_value("branch_target", 32'd0, branch_target);
        end

        for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
            run_row(rows[i], i % 3);
        end

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
exec_data_pkg.sv
exec_ctrl_pkg.sv
alu.sv
operand_select.sv
exec_handshake.sv
exec_unit.sv
exec_unit_sva.sv
tb_clock.sv
exec_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds the execute unit testbench with Verilator and runs it.
verilator --binary --timing --assert --top-module exec_unit_tb -f vlog.f -o exec_unit_sim &&
./obj_dir/exec_unit_sim | awk '{ print } /^Test passed$/ { ok = 1 } END { exit !ok }' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation did not pass"; exit 1; }
